/* design/isa_pkg.sv */
package isa_pkg;

    // major opcodes, LA32R encoding
    localparam logic [16:0] OP_ADD_W   = 17'h00020;  // inst[31:15]
    localparam logic [16:0] OP_SUB_W   = 17'h00022;
    localparam logic [16:0] OP_AND     = 17'h00029;
    localparam logic [16:0] OP_OR      = 17'h0002a;
    localparam logic [9:0]  OP_ADDI_W  = 10'h00a;    // inst[31:22]
    localparam logic [6:0]  OP_LU12I_W = 7'h0a;      // inst[31:25]
    localparam logic [5:0]  OP_BEQ     = 6'h16;      // inst[31:26]
    localparam logic [5:0]  OP_BNE     = 6'h17;
    localparam logic [5:0]  OP_B       = 6'h14;

    // three register view
    typedef struct packed {
        logic [16:0] op;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_3r_t;

    // immediate view, si12 sits in imm16[11:0]
    // lu12i si20 is {imm16[14:0], rj}, b offs26 is {rj, rd, imm16}
    typedef struct packed {
        logic [5:0]  op;
        logic [15:0] imm16;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_2ri_t;

    typedef union packed {
        fmt_3r_t  r3;
        fmt_2ri_t ri;
    } inst_u;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_PASS_B
    } alu_op_e;

endpackage

/* design/pipe_pkg.sv */
package pipe_pkg;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
    } fetch_bus_t;

    // decode back to fetch
    typedef struct packed {
        logic        br_taken;   // single cycle, branch leaving decode
        logic        br_stall;   // branch still waiting in decode
        logic [31:0] br_target;
    } branch_fb_t;

    typedef struct packed {
        logic [31:0]      pc;
        isa_pkg::alu_op_e alu_op;
        logic [31:0]      src_a;
        logic [31:0]      src_b;
        logic [4:0]       dest;
        logic             wen;
    } dec_bus_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] result;
        logic [4:0]  dest;
        logic        wen;
    } exe_bus_t;

endpackage

/* design/reg_file.sv */
`timescale 1ns/10ps

module reg_file (
    input  logic        clk,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);
    logic [31:0] rf [32];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            rf[waddr] <= wdata;
        end
    end

    // r0 reads as zero whatever the array holds
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : rf[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : rf[raddr2];

endmodule

/* design/fetch_stage.sv */
`timescale 1ns/10ps

module fetch_stage #(
    parameter logic [31:0] RESET_PC = 32'h1bff_fffc
) (
    input  logic                 clk,
    input  logic                 resetn,
    output logic                 inst_sram_req,
    output logic [31:0]          inst_sram_addr,
    input  logic                 inst_sram_addr_ok,
    input  logic                 inst_sram_data_ok,
    input  logic [31:0]          inst_sram_rdata,
    input  pipe_pkg::branch_fb_t br_fb,
    input  logic                 dec_allowin,
    output logic                 fetch_valid,
    output pipe_pkg::fetch_bus_t fetch_bus
);
    // pre-stage: request accepted while the stage slot was busy
    logic        pre_reqed;
    logic [31:0] pre_pc_r;
    logic [31:0] pre_ir;
    logic        pre_ir_valid;

    // stage slot, either waiting for its word or holding it
    logic        if_valid;
    logic        if_inst_valid;
    logic        if_cancel;      // in-flight word is stale, drop on return
    logic [31:0] if_pc;
    logic [31:0] if_ir;

    logic [31:0] last_pc;        // address of the last accepted request
    logic [31:0] next_pc;
    logic        br_pend;
    logic [31:0] br_target_r;

    logic        req_fire;
    logic        owner_if;
    logic        pre_data_ok;
    logic        pre_go;
    logic        if_ready_go;
    logic        if_allowin;

    assign req_fire    = inst_sram_req & inst_sram_addr_ok;
    // returns are in order, so the waiting stage slot owns data_ok first
    assign owner_if    = if_valid & ~if_inst_valid;
    assign pre_data_ok = inst_sram_data_ok & ~owner_if;
    assign if_ready_go = if_inst_valid | owner_if & inst_sram_data_ok;
    assign if_allowin  = ~if_valid | if_ready_go & (dec_allowin | if_cancel);
    assign pre_go      = pre_reqed | req_fire;

    assign next_pc = br_pend        ? br_target_r :
                     br_fb.br_taken ? br_fb.br_target :
                                      last_pc + 32'd4;

    // one more request only once the current one has returned or is returning
    assign inst_sram_req  = resetn & ~pre_reqed & ~br_fb.br_stall
                          & (~if_valid | if_ready_go);
    assign inst_sram_addr = next_pc;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            last_pc <= RESET_PC;
            br_pend <= 1'b0;
        end else begin
            if (req_fire) begin
                last_pc <= next_pc;
            end
            if (br_fb.br_taken && !req_fire) begin
                br_pend <= 1'b1;   // target goes out on a later cycle
            end else if (req_fire) begin
                br_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (br_fb.br_taken) begin
            br_target_r <= br_fb.br_target;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pre_reqed    <= 1'b0;
            pre_ir_valid <= 1'b0;
        end else if (if_allowin) begin
            pre_reqed    <= 1'b0;          // moves into the stage slot
            pre_ir_valid <= 1'b0;
        end else begin
            if (req_fire) begin
                pre_reqed <= 1'b1;
            end
            if (pre_data_ok) begin
                pre_ir_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire && !if_allowin) begin
            pre_pc_r <= next_pc;
        end
        if (pre_data_ok && !if_allowin) begin
            pre_ir <= inst_sram_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            if_valid      <= 1'b0;
            if_inst_valid <= 1'b0;
            if_cancel     <= 1'b0;
        end else if (if_allowin) begin
            if_valid      <= pre_go;
            if_inst_valid <= pre_ir_valid | pre_data_ok;
            if_cancel     <= 1'b0;
        end else begin
            if (owner_if && inst_sram_data_ok) begin
                if_inst_valid <= 1'b1;
            end
            // only reached while the slot still waits for its word
            if (br_fb.br_taken) begin
                if_cancel <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (if_allowin && pre_go) begin
            if_pc <= pre_reqed ? pre_pc_r : next_pc;
            if_ir <= pre_ir_valid ? pre_ir : inst_sram_rdata;
        end else if (owner_if && inst_sram_data_ok) begin
            if_ir <= inst_sram_rdata;
        end
    end

    // the word behind a taken branch never enters decode
    assign fetch_valid    = if_ready_go & ~if_cancel & ~br_fb.br_taken;
    assign fetch_bus.pc   = if_pc;
    assign fetch_bus.inst = if_inst_valid ? if_ir : inst_sram_rdata;

    a_no_stray_data : assert property (@(posedge clk) disable iff (!resetn)
        inst_sram_data_ok |-> owner_if || (pre_reqed && !pre_ir_valid))
        else $error("fetch: data_ok with no request outstanding");

endmodule

/* design/decode_stage.sv */
`timescale 1ns/10ps

module decode_stage (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 fetch_valid,
    input  pipe_pkg::fetch_bus_t fetch_bus,
    output logic                 dec_allowin,
    output pipe_pkg::branch_fb_t br_fb,
    input  logic                 exe_allowin,
    output logic                 dec_valid,
    output pipe_pkg::dec_bus_t   dec_bus,
    input  logic                 exe_dest_valid,
    input  logic [4:0]           exe_dest,
    input  logic                 res_dest_valid,
    input  logic [4:0]           res_dest,
    input  logic                 wb_we,
    input  logic [4:0]           wb_addr,
    input  logic [31:0]          wb_data
);
    import isa_pkg::*;
    import pipe_pkg::*;

    fetch_bus_t  fb_r;
    logic        dec_stage_valid;
    logic        dec_ready_go;
    logic        dec_leave;
    inst_u       iw;
    logic        inst_add_w, inst_sub_w, inst_and, inst_or;
    logic        inst_addi_w, inst_lu12i_w, inst_beq, inst_bne, inst_b;
    logic        use_rj, use_r2, rj_hit, r2_hit, is_br, br_cond;
    logic [4:0]  raddr2;
    logic [31:0] rdata1, rdata2, si12, si20, br_offs;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            dec_stage_valid <= 1'b0;
        end else if (dec_allowin) begin
            dec_stage_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid && dec_allowin) begin
            fb_r <= fetch_bus;
        end
    end

    assign iw = fb_r.inst;

    assign inst_add_w   = iw.r3.op == OP_ADD_W;
    assign inst_sub_w   = iw.r3.op == OP_SUB_W;
    assign inst_and     = iw.r3.op == OP_AND;
    assign inst_or      = iw.r3.op == OP_OR;
    assign inst_addi_w  = {iw.ri.op, iw.ri.imm16[15:12]} == OP_ADDI_W;
    assign inst_lu12i_w = {iw.ri.op, iw.ri.imm16[15]} == OP_LU12I_W;
    assign inst_beq     = iw.ri.op == OP_BEQ;
    assign inst_bne     = iw.ri.op == OP_BNE;
    assign inst_b       = iw.ri.op == OP_B;

    // immediates from the 2ri view
    assign si12 = {{20{iw.ri.imm16[11]}}, iw.ri.imm16[11:0]};
    assign si20 = {iw.ri.imm16[14:0], iw.ri.rj, 12'd0};
    assign br_offs = inst_b ? {{4{iw.ri.rj[4]}}, iw.ri.rj, iw.ri.rd, iw.ri.imm16, 2'b00}
                            : {{14{iw.ri.imm16[15]}}, iw.ri.imm16, 2'b00};

    // beq/bne compare rj with rd
    assign is_br  = inst_beq | inst_bne | inst_b;
    assign use_r2 = inst_add_w | inst_sub_w | inst_and | inst_or | inst_beq | inst_bne;
    assign use_rj = use_r2 | inst_addi_w;
    assign raddr2 = (inst_beq | inst_bne) ? iw.r3.rd : iw.r3.rk;

    reg_file u_reg_file (
        .clk    (clk),
        .raddr1 (iw.r3.rj),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (wb_we),
        .waddr  (wb_addr),
        .wdata  (wb_data)
    );

    // no forwarding, wait until the producer has written back
    assign rj_hit = use_rj & (iw.r3.rj != 5'd0)
                  & (exe_dest_valid & (exe_dest == iw.r3.rj)
                   | res_dest_valid & (res_dest == iw.r3.rj));
    assign r2_hit = use_r2 & (raddr2 != 5'd0)
                  & (exe_dest_valid & (exe_dest == raddr2)
                   | res_dest_valid & (res_dest == raddr2));

    assign dec_ready_go = ~(rj_hit | r2_hit);
    assign dec_leave    = dec_stage_valid & dec_ready_go & exe_allowin;
    assign dec_allowin  = ~dec_stage_valid | dec_ready_go & exe_allowin;
    assign dec_valid    = dec_stage_valid & dec_ready_go;

    assign br_cond = inst_b | inst_beq & (rdata1 == rdata2) | inst_bne & (rdata1 != rdata2);
    assign br_fb.br_taken  = dec_leave & br_cond;
    assign br_fb.br_stall  = dec_stage_valid & is_br & ~dec_leave;
    assign br_fb.br_target = fb_r.pc + br_offs;

    assign dec_bus.pc     = fb_r.pc;
    assign dec_bus.alu_op = inst_sub_w   ? ALU_SUB :
                            inst_and     ? ALU_AND :
                            inst_or      ? ALU_OR :
                            inst_lu12i_w ? ALU_PASS_B : ALU_ADD;
    assign dec_bus.src_a  = rdata1;
    assign dec_bus.src_b  = inst_addi_w ? si12 : inst_lu12i_w ? si20 : rdata2;
    assign dec_bus.dest   = iw.r3.rd;
    assign dec_bus.wen    = inst_add_w | inst_sub_w | inst_and | inst_or
                          | inst_addi_w | inst_lu12i_w;   // branches write nothing

    // fetch must drop the word behind a taken branch
    a_br_cancel : assert property (@(posedge clk) disable iff (!resetn)
        br_fb.br_taken |=> !dec_stage_valid)
        else $error("decode: instruction behind a taken branch entered decode");

endmodule

/* design/execute_stage.sv */
`timescale 1ns/10ps

module execute_stage (
    input  logic               clk,
    input  logic               resetn,
    input  logic               dec_valid,
    input  pipe_pkg::dec_bus_t dec_bus,
    output logic               exe_allowin,
    output logic               exe_valid,
    output pipe_pkg::exe_bus_t exe_bus,
    input  logic               res_allowin,
    output logic               exe_dest_valid,
    output logic [4:0]         exe_dest
);
    import isa_pkg::*;
    import pipe_pkg::*;

    dec_bus_t    bus_r;
    logic        exe_stage_valid;
    logic [31:0] alu_result;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            exe_stage_valid <= 1'b0;
        end else if (exe_allowin) begin
            exe_stage_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid && exe_allowin) begin
            bus_r <= dec_bus;
        end
    end

    always_comb begin
        case (bus_r.alu_op)
            ALU_ADD: alu_result = bus_r.src_a + bus_r.src_b;
            ALU_SUB: alu_result = bus_r.src_a - bus_r.src_b;
            ALU_AND: alu_result = bus_r.src_a & bus_r.src_b;
            ALU_OR:  alu_result = bus_r.src_a | bus_r.src_b;
            default: alu_result = bus_r.src_b;   // lu12i
        endcase
    end

    // single cycle ALU, ready as soon as it is valid
    assign exe_allowin = ~exe_stage_valid | res_allowin;
    assign exe_valid   = exe_stage_valid;

    assign exe_bus.pc     = bus_r.pc;
    assign exe_bus.result = alu_result;
    assign exe_bus.dest   = bus_r.dest;
    assign exe_bus.wen    = bus_r.wen;

    assign exe_dest_valid = exe_stage_valid & bus_r.wen;
    assign exe_dest       = bus_r.dest;

endmodule

/* design/result_stage.sv */
`timescale 1ns/10ps

module result_stage (
    input  logic               clk,
    input  logic               resetn,
    input  logic               exe_valid,
    input  pipe_pkg::exe_bus_t exe_bus,
    output logic               res_allowin,
    output logic               wb_we,
    output logic [4:0]         wb_addr,
    output logic [31:0]        wb_data,
    output logic               res_dest_valid,
    output logic [4:0]         res_dest,
    output logic [31:0]        debug_wb_pc,
    output logic               debug_wb_rf_we,
    output logic [4:0]         debug_wb_rf_wnum,
    output logic [31:0]        debug_wb_rf_wdata
);
    import pipe_pkg::*;

    exe_bus_t bus_r;
    logic     res_stage_valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            res_stage_valid <= 1'b0;
        end else begin
            res_stage_valid <= exe_valid;   // write-back never holds
        end
    end

    always_ff @(posedge clk) begin
        if (exe_valid) begin
            bus_r <= exe_bus;
        end
    end

    assign res_allowin = 1'b1;

    // r0 writes dropped here, so they never show on the trace
    assign wb_we   = res_stage_valid & bus_r.wen & (bus_r.dest != 5'd0);
    assign wb_addr = bus_r.dest;
    assign wb_data = bus_r.result;

    assign res_dest_valid = res_stage_valid & bus_r.wen;
    assign res_dest       = bus_r.dest;

    assign debug_wb_pc       = bus_r.pc;
    assign debug_wb_rf_we    = wb_we;
    assign debug_wb_rf_wnum  = bus_r.dest;
    assign debug_wb_rf_wdata = bus_r.result;

endmodule

/* design/cpu_top.sv */
`timescale 1ns/10ps

module cpu_top #(
    parameter logic [31:0] RESET_PC = 32'h1bff_fffc
) (
    input  logic        clk,
    input  logic        resetn,
    output logic        inst_sram_req,
    output logic [31:0] inst_sram_addr,
    input  logic        inst_sram_addr_ok,
    input  logic        inst_sram_data_ok,
    input  logic [31:0] inst_sram_rdata,
    output logic [31:0] debug_wb_pc,
    output logic        debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);
    import pipe_pkg::*;

    logic        fetch_valid;
    fetch_bus_t  fetch_bus;
    logic        dec_allowin;
    branch_fb_t  br_fb;
    logic        dec_valid;
    dec_bus_t    dec_bus;
    logic        exe_allowin;
    logic        exe_valid;
    exe_bus_t    exe_bus;
    logic        res_allowin;
    logic        exe_dest_valid;
    logic [4:0]  exe_dest;
    logic        res_dest_valid;
    logic [4:0]  res_dest;
    logic        wb_we;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;

    // port names line up with the signals above
    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) u_fetch_stage (.*);

    decode_stage u_decode_stage (.*);

    execute_stage u_execute_stage (.*);

    result_stage u_result_stage (.*);

endmodule

/* tb/wb_checker.sv */
`timescale 1ns/10ps

module wb_checker (
    input  logic        clk,
    input  logic        resetn,
    input  logic [31:0] debug_wb_pc,
    input  logic        debug_wb_rf_we,
    input  logic [4:0]  debug_wb_rf_wnum,
    input  logic [31:0] debug_wb_rf_wdata,
    output logic        done,
    output logic        failed
);
    string       exp_name [$];
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_wnum [$];
    logic [31:0] exp_wdata [$];
    int          idx;
    int          test_errs;
    int          pass_cnt;
    int          fail_cnt;
    int          cycles;
    int          limit;

    task automatic load_expected();
        int          fd;
        int          n;
        string       line;
        string       tag;
        string       name;
        logic [31:0] pc;
        logic [4:0]  wnum;
        logic [31:0] wdata;
        fd = $fopen("tb/cpu_cases.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%s %s %h %h %h", tag, name, pc, wnum, wdata);
                if (n == 5 && tag == "exp") begin
                    exp_name.push_back(name);
                    exp_pc.push_back(pc);
                    exp_wnum.push_back(wnum);
                    exp_wdata.push_back(wdata);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic report_counts();
        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    endtask

    task automatic check_writeback();
        logic bad;
        bad = (debug_wb_pc !== exp_pc[idx]) || (debug_wb_rf_wnum !== exp_wnum[idx])
           || (debug_wb_rf_wdata !== exp_wdata[idx]);
        if (bad) begin
            test_errs++;
            $display("** Error %s: expected pc %h r%0d %h, actual pc %h r%0d %h",
                     exp_name[idx], exp_pc[idx], exp_wnum[idx], exp_wdata[idx],
                     debug_wb_pc, debug_wb_rf_wnum, debug_wb_rf_wdata);
        end
        // last entry of this test
        if (idx + 1 == exp_pc.size() || exp_name[idx + 1] != exp_name[idx]) begin
            if (test_errs == 0) begin
                pass_cnt++;
                $display("%s: ok", exp_name[idx]);
            end else begin
                fail_cnt++;
                $display("%s: %0d mismatches", exp_name[idx], test_errs);
            end
            test_errs = 0;
        end
        idx++;
        if (idx == exp_pc.size()) begin
            report_counts();
            failed = (fail_cnt != 0);
            done   = 1'b1;
        end
    endtask

    initial begin
        done      = 1'b0;
        failed    = 1'b0;
        idx       = 0;
        test_errs = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        cycles    = 0;
        load_expected();
        limit = exp_pc.size() * 40 + 200;
        if (exp_pc.size() == 0) begin
            $display("no expected write-backs could be read from tb/cpu_cases.txt");
            failed = 1'b1;
            done   = 1'b1;
        end
        while (!done) begin
            @(posedge clk);
            if (resetn) begin
                cycles++;
                if (debug_wb_rf_we) begin
                    check_writeback();
                end
                if (!done && cycles >= limit) begin
                    $display("write-backs stopped arriving: %0d of %0d seen after %0d cycles",
                             idx, exp_pc.size(), cycles);
                    report_counts();
                    failed = 1'b1;
                    done   = 1'b1;
                end
            end
        end
    end

endmodule

/* tb/tb_top.sv */
`timescale 1ns/10ps

module tb_top;
    localparam logic [31:0] SEED     = 32'hc5c2_c816;
    localparam logic [31:0] RESET_PC = 32'h1bff_fffc;

    logic        clk;
    logic        resetn;
    logic        inst_sram_req;
    logic [31:0] inst_sram_addr;
    logic        inst_sram_addr_ok;
    logic        inst_sram_data_ok;
    logic [31:0] inst_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic        debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;
    logic        chk_done;
    logic        chk_failed;
    bit          load_ok;

    logic [31:0] mem [logic [31:0]];   // sparse program image
    logic [31:0] pend_addr [$];        // accepted requests, oldest first
    int          pend_wait [$];        // cycles left before each return
    int          addr_wait;
    logic [31:0] rng_state;

    cpu_top #(
        .RESET_PC (RESET_PC)
    ) u_cpu_top (.*);

    wb_checker u_wb_checker (
        .clk               (clk),
        .resetn            (resetn),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .done              (chk_done),
        .failed            (chk_failed)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return {addr[15:0], addr[31:16]} ^ 32'h6b8f_29d3;   // filler past the program
    endfunction

    task automatic load_program(output bit ok);
        int          fd;
        int          n;
        string       line;
        string       tag;
        logic [31:0] addr;
        logic [31:0] word;
        ok = 1'b0;
        fd = $fopen("tb/cpu_cases.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%s %h %h", tag, addr, word);
                if (n == 3 && tag == "prog") begin
                    mem[addr] = word;
                end
            end
            $fclose(fd);
            ok = (mem.size() != 0);
        end
    endtask

    // instruction SRAM, in-order returns with random addr_ok and data_ok delays
    always @(posedge clk) begin
        if (!resetn) begin
            inst_sram_addr_ok <= 1'b0;
            inst_sram_data_ok <= 1'b0;
            addr_wait = 0;
            pend_addr.delete();
            pend_wait.delete();
        end else begin
            if (inst_sram_data_ok) begin
                pend_addr.delete(0);   // head was returned this cycle
                pend_wait.delete(0);
            end
            if (inst_sram_req && inst_sram_addr_ok) begin
                pend_addr.push_back(inst_sram_addr);
                rng_state = xorshift32(rng_state);
                pend_wait.push_back(int'(rng_state[1:0]));
                rng_state = xorshift32(rng_state);
                addr_wait = int'(rng_state[1:0]);
            end else if (inst_sram_req && addr_wait > 0) begin
                addr_wait = addr_wait - 1;
            end
            inst_sram_addr_ok <= (addr_wait == 0);
            if (pend_addr.size() == 0) begin
                inst_sram_data_ok <= 1'b0;
            end else if (pend_wait[0] > 0) begin
                pend_wait[0] = pend_wait[0] - 1;
                inst_sram_data_ok <= 1'b0;
            end else begin
                inst_sram_data_ok <= 1'b1;
                inst_sram_rdata   <= read_word(pend_addr[0]);
            end
        end
    end

    initial begin
        clk               = 1'b0;
        resetn            = 1'b0;
        inst_sram_addr_ok = 1'b0;
        inst_sram_data_ok = 1'b0;
        inst_sram_rdata   = 32'd0;
        rng_state         = SEED;
        load_program(load_ok);
        if (!load_ok) begin
            $display("no program words could be read from tb/cpu_cases.txt");
            $display("TEST FAILED");
            $finish;
        end else begin
            repeat (4) @(posedge clk);
            resetn <= 1'b1;
            wait (chk_done);
            if (chk_failed) begin
                $display("TEST FAILED");
            end else begin
                $display("TEST PASSED");
            end
            $finish;
        end
    end

endmodule

/* verilog.f */
design/isa_pkg.sv
design/pipe_pkg.sv
design/reg_file.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/result_stage.sv
design/cpu_top.sv
tb/wb_checker.sv
tb/tb_top.sv

/* Makefile */
# Verilator build and run for the pipeline testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SOURCES   := $(wildcard design/*.sv tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/cpu_cases.txt */
# prog <address> <instruction word>
# exp <test> <pc> <wnum> <wdata>
prog 1c000000 142468a1
prog 1c000004 02bffc02
prog 1c000008 0299e023
prog 1c00000c 00100864
prog 1c000010 00110c45
prog 1c000014 00148c86
prog 1c000018 001504a7
prog 1c00001c 029ffc08
prog 1c000020 00102109
prog 1c000024 0010212a
prog 1c000028 0010094b
prog 1c00002c 58000d08
prog 1c000030 0280040c
prog 1c000034 0280080c
prog 1c000038 02848c0c
prog 1c00003c 50000c00
prog 1c000040 0280140d
prog 1c000044 0280180d
prog 1c000048 0280058d
prog 1c00004c 5c000929
prog 1c000050 0281540e
prog 1c000054 00100c60
prog 1c000058 0010380f
prog 1c00005c 00112df0
prog 1c000060 50000000
exp alu_basic 1c000000 01 12345000
exp alu_basic 1c000004 02 ffffffff
exp alu_basic 1c000008 03 12345678
exp alu_basic 1c00000c 04 12345677
exp alu_basic 1c000010 05 edcba987
exp alu_basic 1c000014 06 12345670
exp alu_basic 1c000018 07 fffff987
exp raw_chain 1c00001c 08 000007ff
exp raw_chain 1c000020 09 00000ffe
exp raw_chain 1c000024 0a 000017fd
exp raw_chain 1c000028 0b 000017fc
exp branch_taken 1c000038 0c 00000123
exp branch_taken 1c000048 0d 00000124
exp branch_not_taken 1c000050 0e 00000055
exp r0_write 1c000058 0f 00000055
exp random_latency 1c00005c 10 ffffe859
